//--- hw/dmiss_config.svh
`ifndef DMISS_CONFIG_SVH
`define DMISS_CONFIG_SVH

// Request ports. Each port can carry one even and one odd line miss per cycle.
`define DM_NUM_PORTS 4

// Bank halves. Half 0 holds even-bank lines and half 1 holds odd-bank lines.
`define DM_NUM_HALVES 2

// Miss entries in each half.
`define DM_SLOTS_PER_HALF 8

// Total miss entries over both halves.
`define DM_NUM_ENTRIES (`DM_NUM_HALVES * `DM_SLOTS_PER_HALF)

// Width of a cache line address.
`define DM_LINE_ADDR_W 36

`endif

//--- hw/dmiss_addr_pkg.sv
`include "dmiss_config.svh"

package dmiss_addr_pkg;

  // A cache line address, with the offset inside the line already removed.
  typedef logic [`DM_LINE_ADDR_W-1:0] line_addr_t;

  // Global entry index. The top bit selects the half.
  typedef logic [$clog2(`DM_NUM_ENTRIES)-1:0] entry_idx_t;

  // Entry index inside one half.
  typedef logic [$clog2(`DM_SLOTS_PER_HALF)-1:0] slot_idx_t;

endpackage

//--- hw/dmiss_entry_pkg.sv
package dmiss_entry_pkg;

  // Life of a miss entry.
  // A replayed entry stays busy until the unlock frees the whole CAM.
  typedef enum logic [1:0] {
    ENTRY_FREE     = 2'd0,
    ENTRY_PENDING  = 2'd1,
    ENTRY_REPLAYED = 2'd2
  } entry_state_e;

endpackage

//--- hw/dmiss_entry.sv
`timescale 1ns/1ns

`include "dmiss_config.svh"

module dmiss_entry (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              write_i,
  input  dmiss_addr_pkg::line_addr_t                        write_addr_i,
  input  logic                                              read_i,
  input  logic                                              unlock_i,
  input  dmiss_addr_pkg::line_addr_t [`DM_NUM_PORTS-1:0]    port_addr_i,
  output logic [`DM_NUM_PORTS-1:0]                          hit_o,
  output logic                                              busy_o,
  output logic                                              pending_o,
  output dmiss_addr_pkg::line_addr_t                        addr_o
);
  import dmiss_addr_pkg::*;
  import dmiss_entry_pkg::*;

  entry_state_e state;
  line_addr_t   addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ENTRY_FREE;
    end else if (unlock_i) begin
      state <= ENTRY_FREE; // Unlock beats a write in the same cycle.
    end else begin
      case (state)
        ENTRY_FREE: begin
          if (write_i) state <= ENTRY_PENDING;
        end
        ENTRY_PENDING: begin
          if (read_i) state <= ENTRY_REPLAYED;
        end
        default: state <= state;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (write_i && state == ENTRY_FREE) addr <= write_addr_i;
  end

  assign busy_o    = (state != ENTRY_FREE);
  assign pending_o = (state == ENTRY_PENDING);

  // A free entry reads as zero.
  assign addr_o = busy_o ? addr : '0;

  // CAM compare against every port of this half.
  always_comb begin
    for (int p = 0; p < `DM_NUM_PORTS; p++) begin
      hit_o[p] = busy_o && (port_addr_i[p] == addr);
    end
  end

endmodule

//--- hw/dmiss_req_filter.sv
`timescale 1ns/1ns

`include "dmiss_config.svh"

module dmiss_req_filter (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic                                                 locked_i,
  input  logic [`DM_NUM_PORTS-1:0]                             req_en_i,
  input  dmiss_addr_pkg::line_addr_t [`DM_NUM_PORTS-1:0]       req_addr_i,
  input  logic [`DM_SLOTS_PER_HALF-1:0][`DM_NUM_PORTS-1:0]     entry_hit_i,
  output logic [`DM_NUM_PORTS-1:0]                             stage_valid_o,
  output dmiss_addr_pkg::line_addr_t [`DM_NUM_PORTS-1:0]       stage_addr_o,
  output logic                                                 stage_busy_o
);

  logic [`DM_NUM_PORTS-1:0] entry_hit;
  logic [`DM_NUM_PORTS-1:0] port_dup;
  logic [`DM_NUM_PORTS-1:0] stage_hit;
  logic [`DM_NUM_PORTS-1:0] keep;

  always_comb begin
    for (int p = 0; p < `DM_NUM_PORTS; p++) begin
      entry_hit[p] = 1'b0;
      port_dup[p]  = 1'b0;
      stage_hit[p] = 1'b0;

      // Line already owned by a busy entry of this half.
      for (int s = 0; s < `DM_SLOTS_PER_HALF; s++) begin
        entry_hit[p] = entry_hit[p] | entry_hit_i[s][p];
      end

      // The highest port with a given line is the one that goes on.
      for (int q = p + 1; q < `DM_NUM_PORTS; q++) begin
        port_dup[p] = port_dup[p] | (req_en_i[q] && req_addr_i[q] == req_addr_i[p]);
      end

      // Covers the cycle where a staged line is not yet in an entry.
      for (int q = 0; q < `DM_NUM_PORTS; q++) begin
        stage_hit[p] = stage_hit[p] |
                       (stage_valid_o[q] && stage_addr_o[q] == req_addr_i[p]);
      end

      keep[p] = req_en_i[p] && !locked_i && !entry_hit[p] && !port_dup[p] && !stage_hit[p];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid_o <= '0;
    end else begin
      stage_valid_o <= keep;
    end
  end

  always_ff @(posedge clk) begin
    stage_addr_o <= req_addr_i;
  end

  assign stage_busy_o = |stage_valid_o;

endmodule

//--- hw/dmiss_alloc.sv
`timescale 1ns/1ns

`include "dmiss_config.svh"

module dmiss_alloc (
  input  logic [`DM_NUM_PORTS-1:0]                            stage_valid_i,
  input  dmiss_addr_pkg::line_addr_t [`DM_NUM_PORTS-1:0]      stage_addr_i,
  input  logic [`DM_SLOTS_PER_HALF-1:0]                       entry_busy_i,
  output logic [`DM_SLOTS_PER_HALF-1:0]                       write_o,
  output dmiss_addr_pkg::line_addr_t [`DM_SLOTS_PER_HALF-1:0] write_addr_o,
  output logic                                                overflow_o
);

  logic [`DM_SLOTS_PER_HALF-1:0] free_slots;
  logic                          claimed;

  // Ports are served lowest first and each takes the lowest slot still free.
  // Every port shrinks the free set seen by the ports after it.
  always_comb begin
    free_slots   = ~entry_busy_i;
    write_o      = '0;
    write_addr_o = '0;
    overflow_o   = 1'b0;
    claimed      = 1'b0;

    for (int p = 0; p < `DM_NUM_PORTS; p++) begin
      claimed = 1'b0;
      if (stage_valid_i[p]) begin
        for (int s = 0; s < `DM_SLOTS_PER_HALF; s++) begin
          if (!claimed && free_slots[s]) begin
            claimed         = 1'b1;
            free_slots[s]   = 1'b0;
            write_o[s]      = 1'b1;
            write_addr_o[s] = stage_addr_i[p];
          end
        end
        if (!claimed) overflow_o = 1'b1; // The request is dropped.
      end
    end
  end

endmodule

//--- hw/dmiss_control.sv
`timescale 1ns/1ns

`include "dmiss_config.svh"

module dmiss_control (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`DM_NUM_HALVES-1:0]     overflow_i,
  input  logic [`DM_NUM_HALVES-1:0]     stage_busy_i,
  input  logic [`DM_NUM_ENTRIES-1:0]    entry_pending_i,
  input  logic [`DM_NUM_ENTRIES-1:0]    entry_busy_i,
  input  logic                          unlock_i,
  output logic                          locked_o,
  output logic                          has_free_o,
  output logic                          replay_start_o
);

  logic started;

  // Any overflow locks the CAM until the unlock.
  always_ff @(posedge clk) begin
    if (rst) begin
      locked_o <= 1'b0;
    end else if (unlock_i) begin
      locked_o <= 1'b0;
    end else if (|overflow_i) begin
      locked_o <= 1'b1;
    end
  end

  // A staged request opens a round of misses.
  // The round ends once nothing is staged and no entry waits for the replay.
  always_ff @(posedge clk) begin
    if (rst) begin
      started        <= 1'b0;
      replay_start_o <= 1'b0;
    end else begin
      replay_start_o <= 1'b0;
      if (|stage_busy_i) begin
        started <= 1'b1;
      end else if (started && !(|entry_pending_i)) begin
        started        <= 1'b0;
        replay_start_o <= 1'b1;
      end
    end
  end

  assign has_free_o = ~&entry_busy_i;

endmodule

//--- hw/dmiss_top.sv
`timescale 1ns/1ns

`include "dmiss_config.svh"

module dmiss_top (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  logic [`DM_NUM_PORTS-1:0][`DM_NUM_HALVES-1:0]            req_en_i,
  input  dmiss_addr_pkg::line_addr_t [`DM_NUM_PORTS-1:0]          req_addr_even_i,
  input  dmiss_addr_pkg::line_addr_t [`DM_NUM_PORTS-1:0]          req_addr_odd_i,
  input  logic                                                    ins_en_i,
  input  dmiss_addr_pkg::entry_idx_t                              ins_req_i,
  input  logic                                                    unlock_i,
  output dmiss_addr_pkg::line_addr_t                              ins_addr_o,
  output logic                                                    has_free_o,
  output logic                                                    locked_o,
  output logic                                                    replay_start_o
);
  import dmiss_addr_pkg::*;

  logic       [`DM_NUM_HALVES-1:0][`DM_NUM_PORTS-1:0]      half_en;
  line_addr_t [`DM_NUM_HALVES-1:0][`DM_NUM_PORTS-1:0]      half_addr;
  logic       [`DM_NUM_HALVES-1:0][`DM_NUM_PORTS-1:0]      stage_valid;
  line_addr_t [`DM_NUM_HALVES-1:0][`DM_NUM_PORTS-1:0]      stage_addr;
  logic       [`DM_NUM_HALVES-1:0]                         stage_busy;
  logic       [`DM_NUM_HALVES-1:0]                         overflow;
  logic       [`DM_NUM_HALVES-1:0][`DM_SLOTS_PER_HALF-1:0]
              [`DM_NUM_PORTS-1:0]                          entry_hit;
  logic       [`DM_NUM_HALVES-1:0][`DM_SLOTS_PER_HALF-1:0] entry_busy;
  logic       [`DM_NUM_HALVES-1:0][`DM_SLOTS_PER_HALF-1:0] entry_pending;
  logic       [`DM_NUM_HALVES-1:0][`DM_SLOTS_PER_HALF-1:0] entry_write;
  line_addr_t [`DM_NUM_HALVES-1:0][`DM_SLOTS_PER_HALF-1:0] write_addr;
  line_addr_t [`DM_NUM_HALVES-1:0][`DM_SLOTS_PER_HALF-1:0] entry_addr;
  logic                                                    ins_half;
  slot_idx_t                                               ins_slot;

  // Half 0 takes the even-bank lines and half 1 the odd-bank lines.
  assign half_addr[0] = req_addr_even_i;
  assign half_addr[1] = req_addr_odd_i;

  always_comb begin
    for (int h = 0; h < `DM_NUM_HALVES; h++) begin
      for (int p = 0; p < `DM_NUM_PORTS; p++) begin
        half_en[h][p] = req_en_i[p][h];
      end
    end
  end

  assign ins_half = ins_req_i[$bits(entry_idx_t)-1];
  assign ins_slot = ins_req_i[$bits(slot_idx_t)-1:0];

  for (genvar h = 0; h < `DM_NUM_HALVES; h++) begin : half_gen
    dmiss_req_filter filter_inst (
      .clk           (clk),
      .rst           (rst),
      .locked_i      (locked_o),
      .req_en_i      (half_en[h]),
      .req_addr_i    (half_addr[h]),
      .entry_hit_i   (entry_hit[h]),
      .stage_valid_o (stage_valid[h]),
      .stage_addr_o  (stage_addr[h]),
      .stage_busy_o  (stage_busy[h])
    );

    dmiss_alloc alloc_inst (
      .stage_valid_i (stage_valid[h]),
      .stage_addr_i  (stage_addr[h]),
      .entry_busy_i  (entry_busy[h]),
      .write_o       (entry_write[h]),
      .write_addr_o  (write_addr[h]),
      .overflow_o    (overflow[h])
    );

    for (genvar s = 0; s < `DM_SLOTS_PER_HALF; s++) begin : entry_gen
      dmiss_entry entry_inst (
        .clk          (clk),
        .rst          (rst),
        .write_i      (entry_write[h][s]),
        .write_addr_i (write_addr[h][s]),
        .read_i       (ins_en_i && ins_half == 1'(h) && ins_slot == slot_idx_t'(s)),
        .unlock_i     (unlock_i),
        .port_addr_i  (half_addr[h]),
        .hit_o        (entry_hit[h][s]),
        .busy_o       (entry_busy[h][s]),
        .pending_o    (entry_pending[h][s]),
        .addr_o       (entry_addr[h][s])
      );
    end
  end

  assign ins_addr_o = ins_en_i ? entry_addr[ins_half][ins_slot] : '0;

  dmiss_control control_inst (
    .clk             (clk),
    .rst             (rst),
    .overflow_i      (overflow),
    .stage_busy_i    (stage_busy),
    .entry_pending_i (entry_pending),
    .entry_busy_i    (entry_busy),
    .unlock_i        (unlock_i),
    .locked_o        (locked_o),
    .has_free_o      (has_free_o),
    .replay_start_o  (replay_start_o)
  );

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

//--- tb/tb_checker.sv
`timescale 1ns/1ns

`include "dmiss_config.svh"

module tb_checker (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic [`DM_NUM_PORTS-1:0][`DM_NUM_HALVES-1:0]   req_en_i,
  input  dmiss_addr_pkg::line_addr_t [`DM_NUM_PORTS-1:0] req_addr_even_i,
  input  dmiss_addr_pkg::line_addr_t [`DM_NUM_PORTS-1:0] req_addr_odd_i,
  input  logic                                           ins_en_i,
  input  dmiss_addr_pkg::entry_idx_t                     ins_req_i,
  input  logic                                           unlock_i,
  input  dmiss_addr_pkg::line_addr_t                     ins_addr_i,
  input  logic                                           has_free_i,
  input  logic                                           locked_i,
  input  logic                                           replay_start_i,
  output int                                             error_count_o,
  output int                                             check_count_o
);
  import dmiss_addr_pkg::*;
  import dmiss_entry_pkg::*;

  localparam int NUM_ENTRIES = `DM_NUM_ENTRIES;
  localparam int SLOTS       = `DM_SLOTS_PER_HALF;
  localparam int PORTS       = `DM_NUM_PORTS;
  localparam int HALVES      = `DM_NUM_HALVES;

  entry_state_e m_state [NUM_ENTRIES];
  line_addr_t   m_addr [NUM_ENTRIES];
  logic         m_stage_valid [HALVES][PORTS];
  line_addr_t   m_stage_addr [HALVES][PORTS];
  logic         m_locked;
  logic         m_started;
  logic         m_replay;
  int           errors;
  int           checks;

  assign error_count_o = errors;
  assign check_count_o = checks;

  function automatic line_addr_t port_addr(input int h, input int p);
    return (h == 0) ? req_addr_even_i[p] : req_addr_odd_i[p];
  endfunction

  task automatic compare_addr(input string name, input line_addr_t exp, input line_addr_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s exp %h got %h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s exp %h got %h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic reset_model();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      m_state[i] = ENTRY_FREE;
      m_addr[i]  = '0;
    end
    for (int h = 0; h < HALVES; h++) begin
      for (int p = 0; p < PORTS; p++) begin
        m_stage_valid[h][p] = 1'b0;
        m_stage_addr[h][p]  = '0;
      end
    end
    m_locked  = 1'b0;
    m_started = 1'b0;
    m_replay  = 1'b0;
  endtask

  // Outputs seen just before the edge, from the state left by the edge before.
  task automatic check_outputs();
    int         idx;
    line_addr_t exp_addr;
    logic       any_free;
    idx      = int'(ins_req_i);
    exp_addr = (ins_en_i && m_state[idx] != ENTRY_FREE) ? m_addr[idx] : '0;
    any_free = 1'b0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (m_state[i] == ENTRY_FREE) any_free = 1'b1;
    end
    compare_addr("ins_addr_o", exp_addr, ins_addr_i);
    compare_bit("has_free_o", any_free, has_free_i);
    compare_bit("locked_o", m_locked, locked_i);
    compare_bit("replay_start_o", m_replay, replay_start_i);
  endtask

  task automatic advance_model();
    logic                   keep [HALVES][PORTS];
    logic [NUM_ENTRIES-1:0] write;
    line_addr_t             write_addr [NUM_ENTRIES];
    logic                   overflow;
    logic                   taken;
    logic                   any_stage;
    logic                   any_pending;
    line_addr_t             req;
    int                     idx;

    // Filter. Busy entries, higher ports and the stage register all veto a request.
    for (int h = 0; h < HALVES; h++) begin
      for (int p = 0; p < PORTS; p++) begin
        req        = port_addr(h, p);
        keep[h][p] = req_en_i[p][h] && !m_locked;
        for (int s = 0; s < SLOTS; s++) begin
          idx = h * SLOTS + s;
          if (m_state[idx] != ENTRY_FREE && m_addr[idx] == req) keep[h][p] = 1'b0;
        end
        for (int q = p + 1; q < PORTS; q++) begin
          if (req_en_i[q][h] && port_addr(h, q) == req) keep[h][p] = 1'b0;
        end
        for (int q = 0; q < PORTS; q++) begin
          if (m_stage_valid[h][q] && m_stage_addr[h][q] == req) keep[h][p] = 1'b0;
        end
      end
    end

    write    = '0;
    overflow = 1'b0;
    for (int h = 0; h < HALVES; h++) begin
      for (int p = 0; p < PORTS; p++) begin
        if (m_stage_valid[h][p]) begin
          taken = 1'b0;
          for (int s = 0; s < SLOTS; s++) begin
            idx = h * SLOTS + s;
            if (!taken && m_state[idx] == ENTRY_FREE && !write[idx]) begin
              taken           = 1'b1;
              write[idx]      = 1'b1;
              write_addr[idx] = m_stage_addr[h][p];
            end
          end
          if (!taken) overflow = 1'b1;
        end
      end
    end

    any_stage   = 1'b0;
    any_pending = 1'b0;
    for (int h = 0; h < HALVES; h++) begin
      for (int p = 0; p < PORTS; p++) any_stage = any_stage | m_stage_valid[h][p];
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (m_state[i] == ENTRY_PENDING) any_pending = 1'b1;
    end

    m_replay = 1'b0;
    if (any_stage) begin
      m_started = 1'b1;
    end else if (m_started && !any_pending) begin
      m_started = 1'b0;
      m_replay  = 1'b1;
    end

    if (unlock_i) m_locked = 1'b0;
    else if (overflow) m_locked = 1'b1;

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (unlock_i) begin
        m_state[i] = ENTRY_FREE; // An allocation at the same edge is lost.
      end else if (m_state[i] == ENTRY_FREE && write[i]) begin
        m_state[i] = ENTRY_PENDING;
        m_addr[i]  = write_addr[i];
      end else if (m_state[i] == ENTRY_PENDING && ins_en_i && int'(ins_req_i) == i) begin
        m_state[i] = ENTRY_REPLAYED;
      end
    end

    for (int h = 0; h < HALVES; h++) begin
      for (int p = 0; p < PORTS; p++) begin
        m_stage_valid[h][p] = keep[h][p];
        m_stage_addr[h][p]  = port_addr(h, p);
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      reset_model();
    end else begin
      check_outputs();
      advance_model();
    end
  end

endmodule

//--- tb/tb_dmiss.sv
`timescale 1ns/1ns

`include "dmiss_config.svh"

module tb_dmiss;
  import dmiss_addr_pkg::*;

  localparam int SEED            = 2;
  localparam int RESET_CYCLES    = 4;
  localparam int DIRECTED_CYCLES = 496; // Generous allowance for the directed phases.
  localparam int RANDOM_CYCLES   = 2000;
  localparam int MARGIN_CYCLES   = 500;
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES;
  localparam int POOL_SIZE       = 12; // A small pool makes lines repeat often.

  logic                                         clk;
  logic                                         rst;
  logic [`DM_NUM_PORTS-1:0][`DM_NUM_HALVES-1:0] req_en;
  line_addr_t [`DM_NUM_PORTS-1:0]               req_addr_even;
  line_addr_t [`DM_NUM_PORTS-1:0]               req_addr_odd;
  logic                                         ins_en;
  entry_idx_t                                   ins_req;
  logic                                         unlock;
  line_addr_t                                   ins_addr;
  logic                                         has_free;
  logic                                         locked;
  logic                                         replay_start;
  int                                           error_count;
  int                                           check_count;
  int                                           cycle_count;
  logic [31:0]                                  rng_state;

  tb_clk_gen #(.PERIOD_NS(100)) clk_gen_inst (.clk_o(clk));

  dmiss_top dmiss_top_inst (
    .clk             (clk),
    .rst             (rst),
    .req_en_i        (req_en),
    .req_addr_even_i (req_addr_even),
    .req_addr_odd_i  (req_addr_odd),
    .ins_en_i        (ins_en),
    .ins_req_i       (ins_req),
    .unlock_i        (unlock),
    .ins_addr_o      (ins_addr),
    .has_free_o      (has_free),
    .locked_o        (locked),
    .replay_start_o  (replay_start)
  );

  tb_checker checker_inst (
    .clk             (clk),
    .rst             (rst),
    .req_en_i        (req_en),
    .req_addr_even_i (req_addr_even),
    .req_addr_odd_i  (req_addr_odd),
    .ins_en_i        (ins_en),
    .ins_req_i       (ins_req),
    .unlock_i        (unlock),
    .ins_addr_i      (ins_addr),
    .has_free_i      (has_free),
    .locked_i        (locked),
    .replay_start_i  (replay_start),
    .error_count_o   (error_count),
    .check_count_o   (check_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
  endtask

  function automatic line_addr_t pool_addr(input int idx);
    return 36'h4_0000_0000 + line_addr_t'(idx) * 36'h0_0010_0101;
  endfunction

  // Inputs change only on the falling edge, and each cycle starts with nothing requested.
  task automatic next_fall();
    @(negedge clk);
    req_en = '0;
    ins_en = 1'b0;
    unlock = 1'b0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) next_fall();
  endtask

  task automatic present_miss(input int port, input int half, input line_addr_t addr);
    req_en[port][half] = 1'b1;
    if (half == 0) req_addr_even[port] = addr;
    else req_addr_odd[port] = addr;
  endtask

  task automatic read_entry(input int idx);
    ins_en  = 1'b1;
    ins_req = entry_idx_t'(idx);
  endtask

  task automatic release_all();
    next_fall();
    unlock = 1'b1;
    idle(2);
  endtask

  task automatic single_miss_phase();
    next_fall();
    present_miss(2, 1, pool_addr(20));
    for (int c = 0; c < 4; c++) begin
      read_entry(8); // Reads zero before the second edge and the line from then on.
      next_fall();
    end
    release_all();
  endtask

  task automatic duplicate_phase();
    next_fall();
    present_miss(0, 0, pool_addr(21));
    present_miss(1, 0, pool_addr(21));
    present_miss(3, 0, pool_addr(21));
    next_fall();
    present_miss(2, 0, pool_addr(21)); // Hits the stage register.
    next_fall();
    present_miss(0, 0, pool_addr(21)); // Hits entry 0.
    next_fall();
    present_miss(1, 0, pool_addr(22));
    for (int i = 0; i < 3; i++) begin
      next_fall();
      read_entry(i);
    end
    release_all();
  endtask

  task automatic port_order_phase();
    next_fall();
    for (int p = 0; p < `DM_NUM_PORTS; p++) present_miss(p, 1, pool_addr(30 + p));
    idle(2);
    for (int i = 8; i < 13; i++) begin
      read_entry(i);
      next_fall();
    end
    release_all();
  endtask

  task automatic overflow_phase();
    for (int b = 0; b < 2; b++) begin
      next_fall();
      for (int p = 0; p < `DM_NUM_PORTS; p++) begin
        present_miss(p, 0, pool_addr(40 + 4 * b + p));
        present_miss(p, 1, pool_addr(50 + 4 * b + p));
      end
    end
    next_fall();
    present_miss(0, 0, pool_addr(48)); // Ninth even line.
    idle(3);
    present_miss(1, 0, pool_addr(49));
    present_miss(2, 1, pool_addr(58));
    read_entry(15);
    idle(3);
    release_all();
    present_miss(3, 0, pool_addr(49));
    idle(3);
    release_all();
  endtask

  task automatic replay_phase();
    next_fall();
    present_miss(0, 0, pool_addr(60));
    present_miss(1, 1, pool_addr(61));
    idle(2);
    read_entry(0);
    next_fall();
    read_entry(8);
    idle(6);
    release_all();
  endtask

  task automatic random_phase();
    logic [31:0] r_en;
    logic [31:0] r_addr;
    logic [31:0] r_ctl;
    repeat (RANDOM_CYCLES) begin
      next_fall();
      next_random(r_en);
      for (int p = 0; p < `DM_NUM_PORTS; p++) begin
        for (int h = 0; h < `DM_NUM_HALVES; h++) begin
          req_en[p][h] = (r_en[3 * (2 * p + h) +: 3] < 3'd3);
        end
        next_random(r_addr);
        req_addr_even[p] = pool_addr(int'(r_addr[7:0]) % POOL_SIZE);
        req_addr_odd[p]  = pool_addr(int'(r_addr[15:8]) % POOL_SIZE);
      end
      next_random(r_ctl);
      ins_en  = r_ctl[0];
      ins_req = r_ctl[4:1];
      unlock  = (r_ctl[10:5] == 6'd0);
    end
  endtask

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rst           = 1'b1;
    req_en        = '0;
    req_addr_even = '0;
    req_addr_odd  = '0;
    ins_en        = 1'b0;
    ins_req       = '0;
    unlock        = 1'b0;
    rng_state     = 32'(SEED);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    single_miss_phase();
    duplicate_phase();
    port_order_phase();
    overflow_phase();
    replay_phase();
    random_phase();
    idle(4);

    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hw
hw/dmiss_addr_pkg.sv
hw/dmiss_entry_pkg.sv
hw/dmiss_entry.sv
hw/dmiss_req_filter.sv
hw/dmiss_alloc.sv
hw/dmiss_control.sv
hw/dmiss_top.sv
tb/tb_clk_gen.sv
tb/tb_checker.sv
tb/tb_dmiss.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in sim.log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns -j 0 -f filelist.f --top-module tb_dmiss \
  && ./obj_dir/Vtb_dmiss | tee sim.log \
  && grep -qx "TB PASSED" sim.log \
  || { echo "simulation failed"; exit 1; }
echo "simulation passed"
